// File: sources.f
+incdir+hw
hw/tetris_ctrl_pkg.sv
hw/tetris_field_pkg.sv
hw/tetris_ifs.sv
hw/shape_table.sv
hw/fit_checker.sv
hw/line_clear.sv
hw/tetris_fsm.sv
hw/tetris_core.sv
verification/tetris_properties.sv
verification/tb_tetris_core.sv

// File: verification/tb_tetris_core.sv
`timescale 1ns/1ps
`include "tetris_defs.svh"

module tb_tetris_core;

  // button bits {right, left, rr, rl, down}
  localparam logic [4:0] B_R  = 5'b10000;
  localparam logic [4:0] B_L  = 5'b01000;
  localparam logic [4:0] B_RR = 5'b00100;
  localparam logic [4:0] B_RL = 5'b00010;
  localparam logic [4:0] B_D  = 5'b00001;
  localparam int N_STEPS    = 23;
  localparam int WAIT_LIMIT = 200;
  localparam int MAX_PIECES = 300;

  logic                     clk;
  logic                     rst;
  logic                     en;
  logic                     right;
  logic                     left;
  logic                     rr;
  logic                     rl;
  logic                     down;
  tetris_field_pkg::grid_t  grid;
  tetris_ctrl_pkg::state_t  state;
  logic                     game_over;
  tetris_field_pkg::piece_t piece;
  logic [7:0]               lines;

  // step word {buttons, hold cycles, repeats}
  // 0 repeats means drop until the piece locks
  logic [15:0] steps [0:N_STEPS-1];

  // reference model of the game
  tetris_field_pkg::grid_t m_field;
  tetris_ctrl_pkg::state_t m_state;
  int m_piece;
  int m_next;
  int m_row;
  int m_col;
  int m_rot;
  int m_lines;
  bit m_locked;

  int checks;
  int errors;
  logic [16:0] lfsr_q;

  tetris_core DUT (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .right     (right),
    .left      (left),
    .rr        (rr),
    .rl        (rl),
    .down      (down),
    .grid      (grid),
    .state     (state),
    .game_over (game_over),
    .piece     (piece),
    .lines     (lines)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // last resort if a wait loop misbehaves
  initial begin
    repeat (400000) @(posedge clk);
    $display("simulation exceeded its cycle limit");
    $display("Test failures found");
    $finish;
  end

  ////////////////////
  // 17 bit fibonacci LFSR with taps 17 and 14
  // one step per bit taken
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[16] ^ lfsr_q[13];
    lfsr_q = {lfsr_q[15:0], fb};
    return fb;
  endfunction

  // box occupancy, bit r*4+c, turned clockwise rot times
  function automatic logic [15:0] box_cells(int p, int rot);
    logic [15:0] m;
    logic [15:0] t;
    case (p)
      0:       m = 16'h00f0;  // I
      1:       m = 16'h0660;  // O
      2:       m = 16'h0072;  // T
      3:       m = 16'h0036;  // S
      4:       m = 16'h0063;  // Z
      5:       m = 16'h0071;  // J
      default: m = 16'h0074;  // L
    endcase
    for (int k = 0; k < rot; k++) begin
      t = '0;
      // (r,c) moves to (c,3-r)
      for (int r = 0; r < 4; r++) begin
        for (int c = 0; c < 4; c++) begin
          if (m[r*4+c]) t[c*4+3-r] = 1'b1;
        end
      end
      m = t;
    end
    return m;
  endfunction

  // inside the walls and on empty cells
  function automatic bit placement_ok(int p, int rot, int row, int col);
    logic [15:0] m;
    int fr;
    int fc;
    m = box_cells(p, rot);
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        fr = row + r;
        fc = col + c;
        if (m[r*4+c]) begin
          if (fr < 0 || fr >= `TETRIS_ROWS || fc < 0 || fc >= `TETRIS_COLS) return 1'b0;
          if (m_field[fr][fc] != '0) return 1'b0;
        end
      end
    end
    return 1'b1;
  endfunction

  // model field with the active piece in its color
  function automatic tetris_field_pkg::grid_t with_piece();
    tetris_field_pkg::grid_t g;
    logic [15:0] m;
    g = m_field;
    m = box_cells(m_piece, m_rot);
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        if (m[r*4+c]) g[m_row+r][m_col+c] = m_piece + 1;
      end
    end
    return g;
  endfunction

  ////////////////////
  task model_spawn();
    m_piece = m_next;
    m_next  = (m_next + 1) % 7;
    m_row   = `SPAWN_ROW;
    m_col   = `SPAWN_COL;
    m_rot   = 0;
    if (placement_ok(m_piece, m_rot, m_row, m_col)) m_state = tetris_ctrl_pkg::PLAY;
    else m_state = tetris_ctrl_pkg::GAME_OVER;
  endtask

  // write piece, drop full rows, count them, spawn the next one
  task model_lock();
    tetris_field_pkg::grid_t kept;
    int dst;
    bit full;
    m_field = with_piece();
    kept    = '0;
    dst     = `TETRIS_ROWS - 1;
    for (int r = `TETRIS_ROWS - 1; r >= 0; r--) begin
      full = 1'b1;
      for (int c = 0; c < `TETRIS_COLS; c++) begin
        if (m_field[r][c] == '0) full = 1'b0;
      end
      if (full) begin
        m_lines++;
      end else begin
        kept[dst] = m_field[r];
        dst--;
      end
    end
    m_field = kept;
    model_spawn();
  endtask

  // priority right, left, rr, rl, down
  task model_move(input logic [4:0] btn);
    int row;
    int col;
    int rot;
    row      = m_row;
    col      = m_col;
    rot      = m_rot;
    m_locked = 1'b0;
    if (btn[4]) col = m_col + 1;
    else if (btn[3]) col = m_col - 1;
    else if (btn[2]) rot = (m_rot + 1) % 4;
    else if (btn[1]) rot = (m_rot + 3) % 4;
    else if (btn[0]) row = m_row + 1;
    if (placement_ok(m_piece, rot, row, col)) begin
      m_row = row;
      m_col = col;
      m_rot = rot;
    end else if (btn == B_D) begin
      model_lock();
      m_locked = 1'b1;
    end
  endtask

  ////////////////////
  task check_val(input string name, input logic [599:0] got, input logic [599:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %0h expected %0h", name, got, exp);
    end
  endtask

  task compare_model();
    if (m_state == tetris_ctrl_pkg::PLAY) check_val("grid", grid, with_piece());
    else check_val("grid", grid, m_field);
    check_val("state", state, m_state);
    check_val("piece", piece, m_piece);
    check_val("lines", lines, m_lines);
    check_val("game_over", game_over, m_state == tetris_ctrl_pkg::GAME_OVER);
  endtask

  // polls on falling edges
  task wait_state(input tetris_ctrl_pkg::state_t a, input tetris_ctrl_pkg::state_t b);
    int n;
    n = 0;
    while (state != a && state != b && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (state != a && state != b) begin
      errors++;
      $display("timeout: state stuck at %0d, expected %0d or %0d", state, a, b);
    end
  endtask

  // one press, held, released, then settled
  task press(input logic [4:0] btn, input int hold);
    @(negedge clk);
    {right, left, rr, rl, down} = btn;
    repeat (hold) @(negedge clk);
    {right, left, rr, rl, down} = 5'b0;
    model_move(btn);
    wait_state(tetris_ctrl_pkg::PLAY, tetris_ctrl_pkg::GAME_OVER);
    compare_model();
  endtask

  task drop_piece(input logic [4:0] btn, input int hold);
    int guard;
    guard    = 0;
    m_locked = 1'b0;
    while (!m_locked && guard < 2 * `TETRIS_ROWS) begin
      press(btn, hold);
      guard++;
    end
  endtask

  task run_step(input int i);
    if (steps[i][7:0] == 0) drop_piece(steps[i][15:11], steps[i][10:8]);
    else repeat (steps[i][7:0]) press(steps[i][15:11], steps[i][10:8]);
  endtask

  task report(input string name, input int e0);
    if (errors == e0) $display("test %s: ok", name);
    else $display("test %s: FAILED with %0d errors", name, errors - e0);
  endtask

  task run_table(input string name, input int first, input int last);
    int e0;
    e0 = errors;
    for (int i = first; i <= last; i++) run_step(i);
    report(name, e0);
  endtask

  ////////////////////
  // stimulus table
  // piece I walls, rotations, then seven pieces fill row 19
  task load_table();
    steps[0]  = {B_L, 3'd1, 8'd4};        // left wall with the last one blocked
    steps[1]  = {B_R, 3'd2, 8'd7};        // right wall
    steps[2]  = {B_RR, 3'd1, 8'd1};
    steps[3]  = {B_R, 3'd1, 8'd2};        // vertical I against the wall
    steps[4]  = {B_RR, 3'd3, 8'd1};       // blocked
    steps[5]  = {B_RL, 3'd1, 8'd1};       // blocked
    steps[6]  = {B_L, 3'd1, 8'd1};
    steps[7]  = {B_RL, 3'd2, 8'd1};
    steps[8]  = {B_L, 3'd1, 8'd6};
    steps[9]  = {B_RR, 3'd1, 8'd4};       // full turn
    steps[10] = {B_D, 3'd1, 8'd0};        // I on cols 0 to 3
    steps[11] = {B_R | B_L, 3'd1, 8'd1};  // right wins
    steps[12] = {B_L | B_D, 3'd2, 8'd1};  // left wins
    steps[13] = {B_D, 3'd1, 8'd0};        // O on cols 4, 5
    steps[14] = {B_R, 3'd1, 8'd3};
    steps[15] = {B_D, 3'd1, 8'd0};        // T on cols 6 to 8
    steps[16] = {B_L, 3'd1, 8'd3};
    steps[17] = {B_D, 3'd1, 8'd0};        // S on the I
    steps[18] = {B_D, 3'd2, 8'd0};        // Z
    steps[19] = {B_D, 3'd1, 8'd0};        // J
    steps[20] = {B_RL, 3'd1, 8'd1};       // L upright, foot left
    steps[21] = {B_R, 3'd1, 8'd5};
    steps[22] = {B_D, 3'd3, 8'd0};        // col 9 closes row 19
  endtask

  ////////////////////
  initial begin
    int e0;
    int n;
    int k;
    int sel;
    logic [4:0] btn;
    logic [`TETRIS_COLS-1:0][`TETRIS_CW-1:0] exp_row;
    rst = 1'b1;
    en = 1'b0;
    {right, left, rr, rl, down} = 5'b0;
    checks  = 0;
    errors  = 0;
    lfsr_q  = 17'd99695;
    m_field = '0;
    m_state = tetris_ctrl_pkg::IDLE;
    m_next  = 0;
    m_lines = 0;
    load_table();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // after reset
    e0 = errors;
    check_val("state", state, tetris_ctrl_pkg::IDLE);
    check_val("grid", grid, '0);
    check_val("game_over", game_over, 1'b0);
    check_val("lines", lines, 8'd0);
    report("reset", e0);

    // first spawn puts a flat I on row 1
    e0 = errors;
    @(negedge clk);
    en = 1'b1;
    @(negedge clk);
    en = 1'b0;
    model_spawn();
    wait_state(tetris_ctrl_pkg::PLAY, tetris_ctrl_pkg::PLAY);
    compare_model();
    exp_row = '0;
    for (int c = 3; c <= 6; c++) exp_row[c] = 3'd1;
    check_val("grid_row1", grid[1], exp_row);
    report("spawn", e0);

    run_table("shift_walls", 0, 1);
    run_table("rotate", 2, 9);

    // seven pieces in order, one full row, next I up
    e0 = errors;
    for (int i = 10; i <= 22; i++) run_step(i);
    check_val("lines", lines, 8'd1);
    check_val("piece", piece, tetris_field_pkg::P_I);
    report("lock_clear", e0);

    // random stacking up to a failed spawn
    e0 = errors;
    n  = 0;
    while (m_state != tetris_ctrl_pkg::GAME_OVER && n < MAX_PIECES) begin
      k = lfsr_bit();
      k = 2 * k + lfsr_bit();
      for (int j = 0; j < k; j++) begin
        sel = lfsr_bit();
        sel = 2 * sel + lfsr_bit();
        case (sel)
          0:       btn = B_R;
          1:       btn = B_L;
          2:       btn = B_RR;
          default: btn = B_RL;
        endcase
        press(btn, 1 + lfsr_bit());
      end
      drop_piece(B_D, 1);
      n++;
    end
    if (m_state != tetris_ctrl_pkg::GAME_OVER) begin
      errors++;
      $display("random stacking did not end in a failed spawn");
    end
    check_val("game_over", game_over, 1'b1);
    check_val("state", state, tetris_ctrl_pkg::GAME_OVER);
    @(negedge clk);
    en = 1'b1;
    @(negedge clk);
    en = 1'b0;
    wait_state(tetris_ctrl_pkg::IDLE, tetris_ctrl_pkg::IDLE);
    check_val("grid", grid, '0);
    check_val("state", state, tetris_ctrl_pkg::IDLE);
    check_val("game_over", game_over, 1'b0);
    report("random_game_over", e0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: verification/tetris_properties.sv
`timescale 1ns/1ps

module tetris_properties (
  input logic                    clk,
  input logic                    rst,
  input tetris_ctrl_pkg::state_t state,
  input logic                    game_over,
  input logic                    fits,
  input logic                    start,
  input logic                    done,
  input logic [7:0]              lines
);

  // start seen, done still owed
  logic pending;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) pending <= 1'b0;
    else if (start) pending <= 1'b1;
    else if (done) pending <= 1'b0;
  end

  ////////////////////
  // game over only after a spawn that did not fit
  a_game_over: assert property (@(posedge clk) disable iff (rst)
    $rose(game_over) |-> $past(state == tetris_ctrl_pkg::SPAWN && !fits))
    else $error("game_over rose without a failed spawn");

  // a clear ends within one scan of the field
  a_start: assert property (@(posedge clk) disable iff (rst)
    start |-> ##[1:40] done)
    else $error("clear start not answered by done");

  a_lines: assert property (@(posedge clk) disable iff (rst)
    lines >= $past(lines))
    else $error("line count went down");

  a_done: assert property (@(posedge clk) disable iff (rst)
    done |-> pending)
    else $error("clear done without a start");

endmodule

bind tetris_fsm tetris_properties u_props (
  .clk       (clk),
  .rst       (rst),
  .state     (state),
  .game_over (game_over),
  .fits      (fit.fits),
  .start     (clr.start),
  .done      (clr.done),
  .lines     (lines)
);

// File: hw/tetris_core.sv
`timescale 1ns/1ps

module tetris_core (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      en,
  input  logic                      right,
  input  logic                      left,
  input  logic                      rr,
  input  logic                      rl,
  input  logic                      down,
  output tetris_field_pkg::grid_t   grid,
  output tetris_ctrl_pkg::state_t   state,
  output logic                      game_over,
  output tetris_field_pkg::piece_t  piece,
  output logic [7:0]                lines
);

  // controller to checker
  fit_if   fit_bus ();
  // controller to clearer
  clear_if clr_bus ();

  ////////////////////
  // game controller
  tetris_fsm u_fsm (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .right     (right),
    .left      (left),
    .rr        (rr),
    .rl        (rl),
    .down      (down),
    .fit       (fit_bus.ctrl),
    .clr       (clr_bus.ctrl),
    .grid      (grid),
    .state     (state),
    .game_over (game_over),
    .piece     (piece),
    .lines     (lines)
  );

  // combinational fit check
  fit_checker u_fit (
    .fit (fit_bus.chk)
  );

  // row removal after each lock
  line_clear u_clear (
    .clk (clk),
    .rst (rst),
    .clr (clr_bus.clearer)
  );

endmodule

// File: hw/tetris_fsm.sv
`timescale 1ns/1ps
`include "tetris_defs.svh"

module tetris_fsm (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      en,
  input  logic                      right,
  input  logic                      left,
  input  logic                      rr,
  input  logic                      rl,
  input  logic                      down,
  fit_if.ctrl                       fit,
  clear_if.ctrl                     clr,
  output tetris_field_pkg::grid_t   grid,
  output tetris_ctrl_pkg::state_t   state,
  output logic                      game_over,
  output tetris_field_pkg::piece_t  piece,
  output logic [7:0]                lines
);

  // locked cells only
  tetris_field_pkg::grid_t   field;
  // locked cells plus the active piece
  tetris_field_pkg::grid_t   drawn;
  tetris_field_pkg::piece_t  nxt;
  tetris_field_pkg::color_t  pcolor;
  tetris_ctrl_pkg::move_t    mv;
  logic [4:0]                row;
  logic signed [4:0]         col;
  tetris_field_pkg::rot_t    rot;
  // occupancy of the active piece, kept from the fit check
  logic [15:0]               cur_mask;
  logic [4:0]                cand_row;
  logic signed [4:0]         cand_col;
  tetris_field_pkg::rot_t    cand_rot;
  tetris_field_pkg::piece_t  cand_piece;
  logic                      any_btn;

  ////////////////////
  // button decode, right wins over left and so on
  always_comb begin
    if (right)     mv = tetris_ctrl_pkg::RIGHT;
    else if (left) mv = tetris_ctrl_pkg::LEFT;
    else if (rr)   mv = tetris_ctrl_pkg::ROR;
    else if (rl)   mv = tetris_ctrl_pkg::ROL;
    else if (down) mv = tetris_ctrl_pkg::DOWN;
    else           mv = tetris_ctrl_pkg::NONE;
  end

  assign any_btn = right | left | rr | rl | down;

  // candidate placement, current one unless spawning or moving
  always_comb begin
    cand_row   = row;
    cand_col   = col;
    cand_rot   = rot;
    cand_piece = piece;
    if (state == tetris_ctrl_pkg::SPAWN) begin
      cand_piece = nxt;
      cand_row   = 5'(`SPAWN_ROW);
      cand_col   = 5'(`SPAWN_COL);
      cand_rot   = '0;
    end else if (state == tetris_ctrl_pkg::PLAY) begin
      case (mv)
        tetris_ctrl_pkg::RIGHT: cand_col = col + 5'sd1;
        tetris_ctrl_pkg::LEFT:  cand_col = col - 5'sd1;
        tetris_ctrl_pkg::ROR:   cand_rot = rot + 2'd1;
        tetris_ctrl_pkg::ROL:   cand_rot = rot - 2'd1;
        tetris_ctrl_pkg::DOWN:  cand_row = row + 5'd1;
        default: ;
      endcase
    end
  end

  assign fit.row   = cand_row;
  assign fit.col   = cand_col;
  assign fit.rot   = cand_rot;
  assign fit.piece = cand_piece;
  assign fit.field = field;

  ////////////////////
  // active piece drawn over the field, also the lock result
  assign pcolor = tetris_field_pkg::color_t'(piece + 3'd1);

  always_comb begin
    int fr;
    int fc;
    drawn = field;
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        fr = int'(row) + r;
        fc = int'(col) + c;
        if (cur_mask[r*4+c] && fr < `TETRIS_ROWS && fc >= 0 && fc < `TETRIS_COLS) begin
          drawn[fr][fc] = pcolor;
        end
      end
    end
  end

  // piece shown only while it can still move
  assign grid = (state == tetris_ctrl_pkg::PLAY || state == tetris_ctrl_pkg::RELEASE)
              ? drawn : field;

  // clearer takes the locked field in the same cycle as we do
  assign clr.start    = (state == tetris_ctrl_pkg::LOCK);
  assign clr.field_in = drawn;
  assign game_over    = (state == tetris_ctrl_pkg::GAME_OVER);

  ////////////////////
  // controller
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= tetris_ctrl_pkg::IDLE;
      field    <= '0;
      piece    <= tetris_field_pkg::P_I;
      nxt      <= tetris_field_pkg::P_I;
      row      <= '0;
      col      <= '0;
      rot      <= '0;
      cur_mask <= '0;
      lines    <= '0;
    end else begin
      case (state)
        tetris_ctrl_pkg::IDLE: begin
          if (en) state <= tetris_ctrl_pkg::SPAWN;
        end
        tetris_ctrl_pkg::SPAWN: begin
          // cyclic order, L wraps to I
          piece <= nxt;
          nxt   <= (nxt == tetris_field_pkg::P_L) ? tetris_field_pkg::P_I
                 : tetris_field_pkg::piece_t'(nxt + 3'd1);
          if (fit.fits) begin
            row      <= cand_row;
            col      <= cand_col;
            rot      <= cand_rot;
            cur_mask <= fit.mask;
            state    <= tetris_ctrl_pkg::PLAY;
          end else begin
            state <= tetris_ctrl_pkg::GAME_OVER;
          end
        end
        tetris_ctrl_pkg::PLAY: begin
          if (mv != tetris_ctrl_pkg::NONE) begin
            if (fit.fits) begin
              row      <= cand_row;
              col      <= cand_col;
              rot      <= cand_rot;
              cur_mask <= fit.mask;
              state    <= tetris_ctrl_pkg::RELEASE;
            end else if (mv == tetris_ctrl_pkg::DOWN) begin
              // landed
              state <= tetris_ctrl_pkg::LOCK;
            end else begin
              state <= tetris_ctrl_pkg::RELEASE;
            end
          end
        end
        tetris_ctrl_pkg::RELEASE: begin
          if (!any_btn) state <= tetris_ctrl_pkg::PLAY;
        end
        tetris_ctrl_pkg::LOCK: begin
          field <= drawn;
          state <= tetris_ctrl_pkg::CLEAR;
        end
        tetris_ctrl_pkg::CLEAR: begin
          if (clr.done) begin
            field <= clr.field_out;
            lines <= lines + 8'(clr.count);
            state <= tetris_ctrl_pkg::SPAWN;
          end
        end
        tetris_ctrl_pkg::GAME_OVER: begin
          // empty field on the way back to IDLE
          if (en) begin
            field <= '0;
            state <= tetris_ctrl_pkg::IDLE;
          end
        end
        default: state <= tetris_ctrl_pkg::IDLE;
      endcase
    end
  end

endmodule

// File: hw/line_clear.sv
`timescale 1ns/1ps
`include "tetris_defs.svh"

module line_clear (
  input logic    clk,
  input logic    rst,
  clear_if.clearer clr
);

  // working copy of the field
  tetris_field_pkg::grid_t work;
  // row under scan, 19 first
  logic [4:0] idx;
  logic       busy;
  logic       done_q;
  logic [2:0] cnt;
  logic       row_full;

  // a row is full when no cell is empty
  always_comb begin
    row_full = 1'b1;
    for (int c = 0; c < `TETRIS_COLS; c++) begin
      if (work[idx][c] == '0) row_full = 1'b0;
    end
  end

  ////////////////////
  // scan control
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy   <= 1'b0;
      done_q <= 1'b0;
      idx    <= '0;
      cnt    <= '0;
    end else begin
      done_q <= 1'b0;
      if (!busy) begin
        // start ignored while busy
        if (clr.start) begin
          busy <= 1'b1;
          idx  <= 5'(`TETRIS_ROWS - 1);
          cnt  <= '0;
        end
      end else if (row_full) begin
        // same index again after the shift
        cnt <= cnt + 3'd1;
      end else if (idx == '0) begin
        // past row 0, done on the next cycle
        busy   <= 1'b0;
        done_q <= 1'b1;
      end else begin
        idx <= idx - 5'd1;
      end
    end
  end

  ////////////////////
  // field copy and row shift
  always_ff @(posedge clk) begin
    if (!busy && clr.start) begin
      work <= clr.field_in;
    end else if (busy && row_full) begin
      // rows above the full one move down by one
      for (int i = `TETRIS_ROWS - 1; i > 0; i--) begin
        if (i <= int'(idx)) work[i] <= work[i-1];
      end
      // empty row enters at the top
      work[0] <= '0;
    end
  end

  assign clr.done      = done_q;
  assign clr.field_out = work;
  assign clr.count     = cnt;

endmodule

// File: hw/fit_checker.sv
`timescale 1ns/1ps
`include "tetris_defs.svh"

module fit_checker (
  fit_if.chk fit
);

  logic [15:0] mask;

  // shape of the candidate piece and rotation
  shape_table u_shape (
    .piece (fit.piece),
    .rot   (fit.rot),
    .mask  (mask)
  );

  // mask goes back so the controller can keep it
  assign fit.mask = mask;

  ////////////////////
  // every occupied box cell must land on an empty field cell
  always_comb begin
    int fr;
    int fc;
    fit.fits = 1'b1;
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        // row is unsigned, col sign extends
        fr = int'(fit.row) + r;
        fc = int'(fit.col) + c;
        if (mask[r*4+c]) begin
          // outside the walls or below the floor
          if (fr >= `TETRIS_ROWS || fc < 0 || fc >= `TETRIS_COLS) begin
            fit.fits = 1'b0;
          end else if (fit.field[fr][fc] != '0) begin
            // already taken
            fit.fits = 1'b0;
          end
        end
      end
    end
  end

endmodule

// File: hw/shape_table.sv
`timescale 1ns/1ps

module shape_table (
  input  tetris_field_pkg::piece_t piece,
  input  tetris_field_pkg::rot_t   rot,
  output logic [15:0]              mask
);

  // [r][c] packing puts cell (r,c) on bit r*4+c
  logic [3:0][3:0] base;
  logic [3:0][3:0] turned;
  logic [3:0][3:0] step;

  ////////////////////
  // base shapes at rot 0
  // bit c of each row nibble is column c
  always_comb begin
    base = '0;
    case (piece)
      tetris_field_pkg::P_I: base[1] = 4'b1111;
      tetris_field_pkg::P_O: begin
        base[1] = 4'b0110;
        base[2] = 4'b0110;
      end
      tetris_field_pkg::P_T: begin
        base[0] = 4'b0010;
        base[1] = 4'b0111;
      end
      tetris_field_pkg::P_S: begin
        base[0] = 4'b0110;
        base[1] = 4'b0011;
      end
      tetris_field_pkg::P_Z: begin
        base[0] = 4'b0011;
        base[1] = 4'b0110;
      end
      tetris_field_pkg::P_J: begin
        base[0] = 4'b0001;
        base[1] = 4'b0111;
      end
      tetris_field_pkg::P_L: begin
        base[0] = 4'b0100;
        base[1] = 4'b0111;
      end
      default: base = '0;
    endcase
  end

  ////////////////////
  // quarter turns, (r,c) goes to (c,3-r)
  always_comb begin
    turned = base;
    step   = '0;
    for (int k = 0; k < 3; k++) begin
      if (k < int'(rot)) begin
        step = '0;
        for (int r = 0; r < 4; r++) begin
          for (int c = 0; c < 4; c++) begin
            step[c][3-r] = turned[r][c];
          end
        end
        turned = step;
      end
    end
  end

  assign mask = turned;

endmodule

// File: hw/tetris_ifs.sv
`timescale 1ns/1ps

// candidate placement out, fit answer back
interface fit_if;
  // box row, never negative, upper guard bit
  logic [4:0]                 row;
  // box col, may go negative near the left wall
  logic signed [4:0]          col;
  tetris_field_pkg::piece_t   piece;
  tetris_field_pkg::rot_t     rot;
  tetris_field_pkg::grid_t    field;
  // same cycle answer
  logic                       fits;
  // occupancy of the candidate, row-major 4x4
  logic [15:0]                mask;

  modport ctrl (output row, col, piece, rot, field, input fits, mask);
  modport chk  (input row, col, piece, rot, field, output fits, mask);
endinterface

// locked field out, cleared field back
interface clear_if;
  logic                     start;
  tetris_field_pkg::grid_t  field_in;
  logic                     done;
  tetris_field_pkg::grid_t  field_out;
  logic [2:0]               count;

  modport ctrl    (output start, field_in, input done, field_out, count);
  modport clearer (input start, field_in, output done, field_out, count);
endinterface

// File: hw/tetris_field_pkg.sv
`include "tetris_defs.svh"

package tetris_field_pkg;

  // cell colors, CL0 is an empty cell
  typedef enum logic [`TETRIS_CW-1:0] {
    CL0, CL1, CL2, CL3, CL4, CL5, CL6, CL7
  } color_t;

  // pieces in spawn order
  // color of a piece is its code plus one
  typedef enum logic [2:0] {
    P_I, P_O, P_T, P_S, P_Z, P_J, P_L
  } piece_t;

  // clockwise quarter turns
  typedef logic [1:0] rot_t;

  // whole playfield, [row][col][color bit]
  typedef logic [`TETRIS_ROWS-1:0][`TETRIS_COLS-1:0][`TETRIS_CW-1:0] grid_t;

endpackage

// File: hw/tetris_ctrl_pkg.sv
package tetris_ctrl_pkg;

  // game controller states
  typedef enum logic [2:0] {
    IDLE,      // waiting for en
    SPAWN,     // place next piece at the top
    PLAY,      // waiting for a button
    RELEASE,   // waiting for all buttons low
    LOCK,      // write piece into the field
    CLEAR,     // line clear running
    GAME_OVER  // spawn did not fit
  } state_t;

  // one button press, decoded by priority
  typedef enum logic [2:0] {
    RIGHT,
    LEFT,
    ROR,   // rotate clockwise
    ROL,   // rotate counter clockwise
    DOWN,
    NONE
  } move_t;

endpackage

// File: hw/tetris_defs.svh
`ifndef TETRIS_DEFS_SVH
`define TETRIS_DEFS_SVH

// playfield size, row 0 is the top row
`define TETRIS_ROWS 20
`define TETRIS_COLS 10

// bits per cell color, 0 means empty
`define TETRIS_CW 3

// top left corner of the 4x4 box at spawn
`define SPAWN_ROW 0
`define SPAWN_COL 3

`endif
